//--- rtl/step_compare_config.svh
/*
  Width and size constants for the lockstep retirement checker.
  Only an XLEN of 32 has been verified.
  Check counters saturate at all ones and do not wrap.
*/
`ifndef STEP_COMPARE_CONFIG_SVH
`define STEP_COMPARE_CONFIG_SVH

// retired pc and register write data width
`define SC_XLEN 32

// destination register index width, x0..x31
`define SC_REG_AW 5

// width of the pc and gpr check counters
`define SC_CNT_W 16

`endif

//--- rtl/step_compare_pkg.sv
/*
  Shared types for the lockstep retirement checker.
  Widths come from step_compare_config.svh.
*/
package step_compare_pkg;

`include "step_compare_config.svh"

   // one retired program counter
   typedef logic [`SC_XLEN-1:0] pc_t;

   // register write data
   typedef logic [`SC_XLEN-1:0] gpr_data_t;

   // destination register index
   typedef logic [`SC_REG_AW-1:0] gpr_addr_t;

   // saturating check counter
   typedef logic [`SC_CNT_W-1:0] check_cnt_t;

   // per-compare mismatch kind
   // bit 0 pc, bit 1 write enable or rd, bit 2 write data
   typedef logic [2:0] mismatch_flags_t;

   // lockstep phases
   typedef enum logic [1:0] {
      S_RUN_DUT,
      S_RUN_REF,
      S_COMPARE
   } sched_state_t;

endpackage

//--- rtl/retire_if.sv
/*
  One held retirement record.
  valid is a level and stays high until the producer is cleared.
  we is already normalized, so a write to x0 shows as no write.
*/
`timescale 1ns/1ps

interface retire_if
   import step_compare_pkg::*;
();

   // record held by the capture
   logic      valid;
   pc_t       pc;
   logic      we;
   gpr_addr_t rd;
   gpr_data_t wdata;

   // capture side
   modport producer (
      output valid,
      output pc,
      output we,
      output rd,
      output wdata
   );

   // comparator side
   modport consumer (
      input valid,
      input pc,
      input we,
      input rd,
      input wdata
   );

endinterface

//--- rtl/retire_capture.sv
/*
  Holds one retirement record from a one-cycle strobe.
  A strobe is taken only while accept_i is high, other strobes are dropped
  and reported on out_of_turn_o. The record is held until clear_i.
*/
`timescale 1ns/1ps

module retire_capture
   import step_compare_pkg::*;
(
   input  logic       ret_rtl,
   input  logic       reset_i,
   input  logic       strobe_valid_i,
   input  pc_t        strobe_pc_i,
   input  logic       strobe_we_i,
   input  gpr_addr_t  strobe_rd_i,
   input  gpr_data_t  strobe_wdata_i,
   input  logic       accept_i,
   input  logic       clear_i,
   retire_if.producer rec,
   output logic       out_of_turn_o
);

   logic      take;
   logic      valid_q;
   pc_t       pc_q;
   logic      we_q;
   gpr_addr_t rd_q;
   gpr_data_t wdata_q;

   // strobe counts only inside its step window
   assign take = strobe_valid_i && accept_i;

   // strobe outside the window, one-cycle pulse
   assign out_of_turn_o = strobe_valid_i && !accept_i;

   // held-valid level
   // a new record wins over a clear in the same cycle
   always_ff @(posedge ret_rtl) begin
      if (reset_i) begin
         valid_q <= 1'b0;
      end else if (take) begin
         valid_q <= 1'b1;
      end else if (clear_i) begin
         valid_q <= 1'b0;
      end
   end

   // payload, x0 writes fold into no write
   always_ff @(posedge ret_rtl) begin
      if (take) begin
         pc_q    <= strobe_pc_i;
         we_q    <= strobe_we_i && (strobe_rd_i != '0);
         rd_q    <= strobe_rd_i;
         wdata_q <= strobe_wdata_i;
      end
   end

   assign rec.valid = valid_q;
   assign rec.pc    = pc_q;
   assign rec.we    = we_q;
   assign rec.rd    = rd_q;
   assign rec.wdata = wdata_q;

endmodule

//--- rtl/step_scheduler.sv
/*
  Lockstep scheduler: core first, then reference, then one compare cycle.
  Step levels are decoded from the state register and the held-valid levels
  only, so they switch on the same edge that captures a record.
  Producers must wait for their step level, there is no other back-pressure.
*/
`timescale 1ns/1ps

module step_scheduler
   import step_compare_pkg::*;
(
   input  logic ret_rtl,
   input  logic reset_i,
   input  logic dut_captured_i,
   input  logic ref_captured_i,
   output logic step_dut_o,
   output logic step_ref_o,
   output logic compare_o
);

   sched_state_t state_q;
   sched_state_t state_cur;
   sched_state_t state_nxt;

   // effective phase
   // a freshly held record moves the phase on at once
   always_comb begin
      state_cur = state_q;
      case (state_q)
         S_RUN_DUT: begin
            if (dut_captured_i) begin
               state_cur = S_RUN_REF;
            end
         end
         S_RUN_REF: begin
            if (ref_captured_i) begin
               state_cur = S_COMPARE;
            end
         end
         default: begin
            // compare is never stored, treat as a pending compare
            state_cur = S_COMPARE;
         end
      endcase
   end

   // compare lasts one cycle, then back to the core
   always_comb begin
      if (state_cur == S_COMPARE) begin
         state_nxt = S_RUN_DUT;
      end else begin
         state_nxt = state_cur;
      end
   end

   always_ff @(posedge ret_rtl) begin
      if (reset_i) begin
         state_q <= S_RUN_DUT;
      end else begin
         state_q <= state_nxt;
      end
   end

   // at most one step level at a time
   assign step_dut_o = (state_cur == S_RUN_DUT);
   assign step_ref_o = (state_cur == S_RUN_REF);

   // evaluate and clear both captures
   assign compare_o  = (state_cur == S_COMPARE);

endmodule

//--- rtl/retire_comparator.sv
/*
  Compares the held core and reference records on compare_i.
  Results register on the next edge together with compare_done_o.
  Only the first mismatch is kept, counters saturate at all ones.
  Data is compared only when both sides write.
*/
`timescale 1ns/1ps

module retire_comparator
   import step_compare_pkg::*;
(
   input  logic            ret_rtl,
   input  logic            reset_i,
   input  logic            compare_i,
   retire_if.consumer      dut_rec,
   retire_if.consumer      ref_rec,
   output logic            compare_done_o,
   output logic            mismatch_o,
   output mismatch_flags_t mismatch_kind_o,
   output pc_t             mismatch_pc_o,
   output check_cnt_t      pc_checks_o,
   output check_cnt_t      gpr_checks_o
);

   logic            evaluate;
   logic            gpr_check;
   logic            both_write;
   mismatch_flags_t flags;

   logic            done_q;
   logic            mismatch_q;
   mismatch_flags_t kind_q;
   pc_t             mis_pc_q;
   check_cnt_t      pc_cnt_q;
   check_cnt_t      gpr_cnt_q;

   // both records must be held
   assign evaluate   = compare_i && dut_rec.valid && ref_rec.valid;

   // register check when either side writes
   assign gpr_check  = dut_rec.we || ref_rec.we;
   assign both_write = dut_rec.we && ref_rec.we;

   // rd only matters when the core writes
   always_comb begin
      flags    = '0;
      flags[0] = (dut_rec.pc != ref_rec.pc);
      flags[1] = (dut_rec.we != ref_rec.we) || (both_write && (dut_rec.rd != ref_rec.rd));
      flags[2] = both_write && (dut_rec.wdata != ref_rec.wdata);
   end

   // done pulse one edge after the compare request
   always_ff @(posedge ret_rtl) begin
      if (reset_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= evaluate;
      end
   end

   // saturating check counters
   always_ff @(posedge ret_rtl) begin
      if (reset_i) begin
         pc_cnt_q  <= '0;
         gpr_cnt_q <= '0;
      end else if (evaluate) begin
         if (pc_cnt_q != '1) begin
            pc_cnt_q <= pc_cnt_q + check_cnt_t'(1);
         end
         if (gpr_check && (gpr_cnt_q != '1)) begin
            gpr_cnt_q <= gpr_cnt_q + check_cnt_t'(1);
         end
      end
   end

   // first mismatch capture, sticky until reset
   always_ff @(posedge ret_rtl) begin
      if (reset_i) begin
         mismatch_q <= 1'b0;
         kind_q     <= '0;
         mis_pc_q   <= '0;
      end else if (evaluate && (flags != '0) && !mismatch_q) begin
         mismatch_q <= 1'b1;
         kind_q     <= flags;
         // the core's pc, not the reference's
         mis_pc_q   <= dut_rec.pc;
      end
   end

   assign compare_done_o  = done_q;
   assign mismatch_o      = mismatch_q;
   assign mismatch_kind_o = kind_q;
   assign mismatch_pc_o   = mis_pc_q;
   assign pc_checks_o     = pc_cnt_q;
   assign gpr_checks_o    = gpr_cnt_q;

endmodule

//--- rtl/step_compare_top.sv
/*
  Lockstep retirement checker top level.
  valid inputs are one-cycle strobes, honored only while the matching
  step output is high. Any other strobe sets the sticky protocol_error_o.
  compare_done_o follows an accepted reference strobe by 2 edges.
*/
`timescale 1ns/1ps

module step_compare_top
   import step_compare_pkg::*;
(
   input  logic            ret_rtl,
   input  logic            reset_i,
   // core retirement
   input  logic            dut_valid_i,
   input  pc_t             dut_pc_i,
   input  logic            dut_we_i,
   input  gpr_addr_t       dut_rd_i,
   input  gpr_data_t       dut_wdata_i,
   // reference retirement
   input  logic            ref_valid_i,
   input  pc_t             ref_pc_i,
   input  logic            ref_we_i,
   input  gpr_addr_t       ref_rd_i,
   input  gpr_data_t       ref_wdata_i,
   // step levels and results
   output logic            step_dut_o,
   output logic            step_ref_o,
   output logic            compare_done_o,
   output logic            mismatch_o,
   output mismatch_flags_t mismatch_kind_o,
   output pc_t             mismatch_pc_o,
   output check_cnt_t      pc_checks_o,
   output check_cnt_t      gpr_checks_o,
   output logic            protocol_error_o
);

   retire_if dut_rec ();
   retire_if ref_rec ();

   logic compare;
   logic dut_out_of_turn;
   logic ref_out_of_turn;
   logic protocol_error_q;

   // core side, open while step_dut_o is high
   retire_capture dut_capture_inst (
      .ret_rtl        (ret_rtl),
      .reset_i        (reset_i),
      .strobe_valid_i (dut_valid_i),
      .strobe_pc_i    (dut_pc_i),
      .strobe_we_i    (dut_we_i),
      .strobe_rd_i    (dut_rd_i),
      .strobe_wdata_i (dut_wdata_i),
      .accept_i       (step_dut_o),
      .clear_i        (compare),
      .rec            (dut_rec.producer),
      .out_of_turn_o  (dut_out_of_turn)
   );

   // reference side
   retire_capture ref_capture_inst (
      .ret_rtl        (ret_rtl),
      .reset_i        (reset_i),
      .strobe_valid_i (ref_valid_i),
      .strobe_pc_i    (ref_pc_i),
      .strobe_we_i    (ref_we_i),
      .strobe_rd_i    (ref_rd_i),
      .strobe_wdata_i (ref_wdata_i),
      .accept_i       (step_ref_o),
      .clear_i        (compare),
      .rec            (ref_rec.producer),
      .out_of_turn_o  (ref_out_of_turn)
   );

   step_scheduler scheduler_inst (
      .ret_rtl        (ret_rtl),
      .reset_i        (reset_i),
      .dut_captured_i (dut_rec.valid),
      .ref_captured_i (ref_rec.valid),
      .step_dut_o     (step_dut_o),
      .step_ref_o     (step_ref_o),
      .compare_o      (compare)
   );

   retire_comparator comparator_inst (
      .ret_rtl         (ret_rtl),
      .reset_i         (reset_i),
      .compare_i       (compare),
      .dut_rec         (dut_rec.consumer),
      .ref_rec         (ref_rec.consumer),
      .compare_done_o  (compare_done_o),
      .mismatch_o      (mismatch_o),
      .mismatch_kind_o (mismatch_kind_o),
      .mismatch_pc_o   (mismatch_pc_o),
      .pc_checks_o     (pc_checks_o),
      .gpr_checks_o    (gpr_checks_o)
   );

   // sticky out-of-turn report
   always_ff @(posedge ret_rtl) begin
      if (reset_i) begin
         protocol_error_q <= 1'b0;
      end else if (dut_out_of_turn || ref_out_of_turn) begin
         protocol_error_q <= 1'b1;
      end
   end

   assign protocol_error_o = protocol_error_q;

endmodule

//--- testbench/step_compare_checker.sv
/*
  Assertions on the lockstep step levels and the compare pulse.
  Bound into step_compare_top, inactive while reset_i is high.
*/
`timescale 1ns/1ps

module step_compare_checker (
   input logic ret_rtl,
   input logic reset_i,
   input logic ref_valid_i,
   input logic step_dut_i,
   input logic step_ref_i,
   input logic compare_done_i
);

   // only one side runs at a time
   one_step_level_a: assert property (@(posedge ret_rtl) disable iff (reset_i)
      !(step_dut_i && step_ref_i))
      else $error("step_dut_o and step_ref_o high together");

   // accepted reference strobe to done, fixed 2 edges
   done_latency_a: assert property (@(posedge ret_rtl) disable iff (reset_i)
      (ref_valid_i && step_ref_i) |-> ##2 compare_done_i)
      else $error("compare_done_o not 2 cycles after reference strobe");

   // single-cycle done pulse
   done_pulse_a: assert property (@(posedge ret_rtl) disable iff (reset_i)
      compare_done_i |=> !compare_done_i)
      else $error("compare_done_o longer than one cycle");

   // core restarts only with the done pulse
   dut_restart_a: assert property (@(posedge ret_rtl) disable iff (reset_i)
      $rose(step_dut_i) |-> compare_done_i)
      else $error("step_dut_o rose without compare_done_o");

endmodule

//--- testbench/step_compare_tb.sv
/*
  Directed testbench for step_compare_top.
  Inputs change and outputs are sampled on the falling edge.
  Random data and delays come from a 32-bit Galois LFSR, seed 32.
*/
`timescale 1ns/1ps

module step_compare_tb
   import step_compare_pkg::*;
();

   localparam int MAX_DELAY      = 7;
   localparam int TOTAL_STEPS    = 37;
   localparam int TOTAL_RESETS   = 7;
   // worst step is core strobe, ref delay, ref strobe, compare, done
   localparam int TIMEOUT_CYCLES = TOTAL_STEPS * (MAX_DELAY + 6) + TOTAL_RESETS * 4 + 50;

   logic            ret_rtl;
   logic            reset_i;
   logic            dut_valid_i;
   pc_t             dut_pc_i;
   logic            dut_we_i;
   gpr_addr_t       dut_rd_i;
   gpr_data_t       dut_wdata_i;
   logic            ref_valid_i;
   pc_t             ref_pc_i;
   logic            ref_we_i;
   gpr_addr_t       ref_rd_i;
   gpr_data_t       ref_wdata_i;
   logic            step_dut_o;
   logic            step_ref_o;
   logic            compare_done_o;
   logic            mismatch_o;
   mismatch_flags_t mismatch_kind_o;
   pc_t             mismatch_pc_o;
   check_cnt_t      pc_checks_o;
   check_cnt_t      gpr_checks_o;
   logic            protocol_error_o;

   logic [31:0]     lfsr_q;
   int              cycle_cnt = 0;

   step_compare_top step_compare_inst (.*);

   bind step_compare_top step_compare_checker step_checker_inst (
      .ret_rtl        (ret_rtl),
      .reset_i        (reset_i),
      .ref_valid_i    (ref_valid_i),
      .step_dut_i     (step_dut_o),
      .step_ref_i     (step_ref_o),
      .compare_done_i (compare_done_o)
   );

   // 8 ns period
   always #4 ret_rtl = ~ret_rtl;

   always @(posedge ret_rtl) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("timeout, run did not finish in %0d cycles", TIMEOUT_CYCLES));
      end
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_pc(input string name, input pc_t got, input pc_t exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %0t %s got %h exp %h", $time, name, got, exp));
      end
   endtask

   task automatic check_flags(input string name, input mismatch_flags_t got,
                              input mismatch_flags_t exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %0t %s got %b exp %b", $time, name, got, exp));
      end
   endtask

   task automatic check_cnt(input string name, input check_cnt_t got, input check_cnt_t exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %0t %s got %0d exp %0d", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %0t %s got %b exp %b", $time, name, got, exp));
      end
   endtask

   // right-shift Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         lfsr_next = (s >> 1) ^ 32'h8020_0003;
      end else begin
         lfsr_next = s >> 1;
      end
   endfunction

   // one lfsr step per bit
   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   task automatic apply_reset();
      @(negedge ret_rtl);
      reset_i     = 1'b1;
      dut_valid_i = 1'b0;
      ref_valid_i = 1'b0;
      repeat (3) @(negedge ret_rtl);
      reset_i = 1'b0;
      check_bit("step_dut_o", step_dut_o, 1'b1);
      check_bit("step_ref_o", step_ref_o, 1'b0);
      check_bit("compare_done_o", compare_done_o, 1'b0);
      check_bit("mismatch_o", mismatch_o, 1'b0);
      check_bit("protocol_error_o", protocol_error_o, 1'b0);
      check_cnt("pc_checks_o", pc_checks_o, '0);
      check_cnt("gpr_checks_o", gpr_checks_o, '0);
   endtask

   task automatic strobe_dut(input pc_t pc, input logic we, input gpr_addr_t rd,
                             input gpr_data_t wdata);
      dut_valid_i = 1'b1;
      dut_pc_i    = pc;
      dut_we_i    = we;
      dut_rd_i    = rd;
      dut_wdata_i = wdata;
      @(negedge ret_rtl);
      dut_valid_i = 1'b0;
   endtask

   task automatic strobe_ref(input pc_t pc, input logic we, input gpr_addr_t rd,
                             input gpr_data_t wdata);
      ref_valid_i = 1'b1;
      ref_pc_i    = pc;
      ref_we_i    = we;
      ref_rd_i    = rd;
      ref_wdata_i = wdata;
      @(negedge ret_rtl);
      ref_valid_i = 1'b0;
   endtask

   task automatic wait_done();
      while (compare_done_o !== 1'b1) @(negedge ret_rtl);
      // core is released with the done pulse
      check_bit("step_dut_o", step_dut_o, 1'b1);
   endtask

   // one lockstep step, reference held back by delay cycles
   task automatic do_step(input pc_t pc, input logic we, input gpr_addr_t rd,
                          input gpr_data_t wdata, input pc_t r_pc, input logic r_we,
                          input gpr_addr_t r_rd, input gpr_data_t r_wdata, input int delay);
      while (step_dut_o !== 1'b1) @(negedge ret_rtl);
      strobe_dut(pc, we, rd, wdata);
      check_bit("step_dut_o", step_dut_o, 1'b0);
      check_bit("step_ref_o", step_ref_o, 1'b1);
      repeat (delay) @(negedge ret_rtl);
      while (step_ref_o !== 1'b1) @(negedge ret_rtl);
      strobe_ref(r_pc, r_we, r_rd, r_wdata);
      check_bit("step_ref_o", step_ref_o, 1'b0);
      wait_done();
   endtask

   task automatic match_step(input pc_t pc, input logic we, input gpr_addr_t rd,
                             input gpr_data_t wdata, input int delay);
      do_step(pc, we, rd, wdata, pc, we, rd, wdata, delay);
   endtask

   task automatic test_matching_stream();
      check_cnt_t exp_gpr;
      logic       we;
      gpr_addr_t  rd;
      apply_reset();
      exp_gpr = '0;
      for (int i = 0; i < 8; i++) begin
         // even steps write, step 0 writes x0
         we = ((i % 2) == 0);
         rd = gpr_addr_t'(i);
         match_step(pc_t'(32'h1000 + 4 * i), we, rd, gpr_data_t'(32'hA5A5_0000 + i), i % 3);
         if (we && (rd != '0)) begin
            exp_gpr++;
         end
      end
      check_bit("mismatch_o", mismatch_o, 1'b0);
      check_cnt("pc_checks_o", pc_checks_o, check_cnt_t'(8));
      check_cnt("gpr_checks_o", gpr_checks_o, exp_gpr);
   endtask

   task automatic test_pc_mismatch();
      pc_t       pc;
      pc_t       r_pc;
      gpr_data_t r_wdata;
      apply_reset();
      for (int i = 1; i <= 5; i++) begin
         pc      = pc_t'(32'h2000 + 4 * i);
         r_pc    = (i == 3) ? (pc ^ pc_t'(32'h40)) : pc;
         // step 5 differs in data and must not replace the first capture
         r_wdata = (i == 5) ? gpr_data_t'(32'hDEAD) : gpr_data_t'(i);
         do_step(pc, 1'b1, gpr_addr_t'(i), gpr_data_t'(i), r_pc, 1'b1, gpr_addr_t'(i),
                 r_wdata, 1);
         if (i >= 3) begin
            check_bit("mismatch_o", mismatch_o, 1'b1);
            check_flags("mismatch_kind_o", mismatch_kind_o, 3'b001);
            check_pc("mismatch_pc_o", mismatch_pc_o, pc_t'(32'h200C));
         end else begin
            check_bit("mismatch_o", mismatch_o, 1'b0);
         end
      end
      check_cnt("pc_checks_o", pc_checks_o, check_cnt_t'(5));
   endtask

   task automatic test_field_mismatch();
      apply_reset();
      do_step(32'h3000, 1'b1, 5'd7, 32'h1111, 32'h3000, 1'b1, 5'd7, 32'h2222, 2);
      check_bit("mismatch_o", mismatch_o, 1'b1);
      check_flags("mismatch_kind_o", mismatch_kind_o, 3'b100);
      check_pc("mismatch_pc_o", mismatch_pc_o, 32'h3000);
      apply_reset();
      do_step(32'h3004, 1'b1, 5'd7, 32'h1111, 32'h3004, 1'b1, 5'd9, 32'h1111, 0);
      check_bit("mismatch_o", mismatch_o, 1'b1);
      check_flags("mismatch_kind_o", mismatch_kind_o, 3'b010);
      check_pc("mismatch_pc_o", mismatch_pc_o, 32'h3004);
   endtask

   task automatic test_x0_write();
      apply_reset();
      do_step(32'h3100, 1'b1, 5'd0, 32'h5555, 32'h3100, 1'b0, 5'd0, 32'h0, 1);
      check_bit("mismatch_o", mismatch_o, 1'b0);
      check_cnt("pc_checks_o", pc_checks_o, check_cnt_t'(1));
      check_cnt("gpr_checks_o", gpr_checks_o, '0);
   endtask

   task automatic test_out_of_turn();
      apply_reset();
      strobe_dut(32'h4000, 1'b1, 5'd3, 32'h4444);
      check_bit("step_dut_o", step_dut_o, 1'b0);
      // second core strobe while the reference is pending
      strobe_dut(32'h4004, 1'b1, 5'd4, 32'h9999);
      check_bit("protocol_error_o", protocol_error_o, 1'b1);
      check_cnt("pc_checks_o", pc_checks_o, '0);
      check_cnt("gpr_checks_o", gpr_checks_o, '0);
      strobe_ref(32'h4000, 1'b1, 5'd3, 32'h4444);
      wait_done();
      check_bit("mismatch_o", mismatch_o, 1'b0);
      check_bit("protocol_error_o", protocol_error_o, 1'b1);
      check_cnt("pc_checks_o", pc_checks_o, check_cnt_t'(1));
   endtask

   task automatic test_random_stream();
      logic [31:0] bits;
      logic        we;
      gpr_addr_t   rd;
      gpr_data_t   wdata;
      int          delay;
      check_cnt_t  exp_gpr;
      apply_reset();
      exp_gpr = '0;
      for (int i = 0; i < 20; i++) begin
         take_bits(1, bits);
         we = bits[0];
         take_bits(5, bits);
         rd = gpr_addr_t'(bits);
         take_bits(32, bits);
         wdata = bits;
         take_bits(3, bits);
         delay = int'(bits);
         match_step(pc_t'(32'h8000 + 4 * i), we, rd, wdata, delay);
         if (we && (rd != '0)) begin
            exp_gpr++;
         end
      end
      check_bit("mismatch_o", mismatch_o, 1'b0);
      check_cnt("pc_checks_o", pc_checks_o, check_cnt_t'(20));
      check_cnt("gpr_checks_o", gpr_checks_o, exp_gpr);
   endtask

   initial begin
      ret_rtl     = 1'b0;
      reset_i     = 1'b1;
      dut_valid_i = 1'b0;
      dut_pc_i    = '0;
      dut_we_i    = 1'b0;
      dut_rd_i    = '0;
      dut_wdata_i = '0;
      ref_valid_i = 1'b0;
      ref_pc_i    = '0;
      ref_we_i    = 1'b0;
      ref_rd_i    = '0;
      ref_wdata_i = '0;
      lfsr_q      = 32'd32;
      test_matching_stream();
      test_pc_mismatch();
      test_field_mismatch();
      test_x0_write();
      test_out_of_turn();
      test_random_stream();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- step_compare.f
+incdir+rtl
rtl/step_compare_pkg.sv
rtl/retire_if.sv
rtl/retire_capture.sv
rtl/step_scheduler.sv
rtl/retire_comparator.sv
rtl/step_compare_top.sv
testbench/step_compare_checker.sv
testbench/step_compare_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = step_compare_tb
FILELIST  = step_compare.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
